// ==== bench/tbYuvToRgb.sv ====
// directed tests only; rtl/ must be on the include path and every line is at most 256 pairs
`timescale 1ns/1ps
`default_nettype none

`include "yuvRgb_params.svh"

module tbYuvToRgb;

  localparam int CLK_PERIOD  = 40;
  localparam int TOTAL_PAIRS = 3 * `LINE_DEFAULT + 3 * 4 + 8;
  localparam int TIME_LIMIT  = CLK_PERIOD * 4 * TOTAL_PAIRS + CLK_PERIOD * 400;

  logic Clock_50_I;
  logic Resetn;
  yuvRgbPkg::yuvPair_t inPair;
  logic inValid;
  logic rgbReady;
  logic cfgWrite;
  yuvRgbPkg::lineLen_t cfgData;
  logic inReady;
  yuvRgbPkg::rgbPair_t rgbPair;
  logic rgbValid;
  yuvRgbPkg::lineLen_t lineLength;
  logic cfgError;

  // samples of the line being sent
  int yE[256];
  int yO[256];
  int uS[256];
  int vS[256];

  yuvRgbPkg::rgbPair_t expQ[$];
  logic randomReady;

  yuvToRgbTop u_dut (
    .Clock_50_I (Clock_50_I),
    .Resetn     (Resetn),
    .inPair     (inPair),
    .inValid    (inValid),
    .rgbReady   (rgbReady),
    .cfgWrite   (cfgWrite),
    .cfgData    (cfgData),
    .inReady    (inReady),
    .rgbPair    (rgbPair),
    .rgbValid   (rgbValid),
    .lineLength (lineLength),
    .cfgError   (cfgError)
  );

  initial begin
    Clock_50_I = 1'b0;
    forever #(CLK_PERIOD / 2) Clock_50_I = ~Clock_50_I;
  end

  task automatic stopRun(input string why);
    $display("%s", why);
    $display("Testbench failed");
    $fatal(1, "run stopped at first error");
  endtask

  initial begin
    #(TIME_LIMIT);
    stopRun("Timeout: the DUT did not finish the tests in the allowed time");
  end

  always @(negedge Clock_50_I) begin
    if (randomReady) begin
      rgbReady <= 1'($urandom_range(0, 1));
    end else begin
      rgbReady <= 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // reference model

  function automatic int clip8(input int x);
    if (x < 0) begin
      return 0;
    end
    if (x > 255) begin
      return 255;
    end
    return x;
  endfunction

  // chroma sample with the index clamped to the line
  function automatic int chromaAt(input bit useV, input int idx, input int len);
    int k;
    k = (idx < 0) ? 0 : ((idx > len - 1) ? len - 1 : idx);
    return useV ? vS[k] : uS[k];
  endfunction

  function automatic int oddChromaRef(input bit useV, input int j, input int len);
    int acc;
    acc = `FIR_C0 * (chromaAt(useV, j - 2, len) + chromaAt(useV, j + 3, len))
        - `FIR_C1 * (chromaAt(useV, j - 1, len) + chromaAt(useV, j + 2, len))
        + `FIR_C2 * (chromaAt(useV, j, len) + chromaAt(useV, j + 1, len))
        + `FIR_ROUND;
    return clip8(acc >>> `FIR_SHIFT);
  endfunction

  function automatic logic [23:0] rgbRef(input int y, input int u, input int v);
    int yTerm;
    int r;
    int g;
    int b;
    yTerm = `COEF_Y * (y - `Y_OFFSET);
    r = (yTerm + `COEF_RV * (v - `C_OFFSET)) >>> `CSC_SHIFT;
    g = (yTerm - `COEF_GU * (u - `C_OFFSET) - `COEF_GV * (v - `C_OFFSET)) >>> `CSC_SHIFT;
    b = (yTerm + `COEF_BU * (u - `C_OFFSET)) >>> `CSC_SHIFT;
    return {8'(clip8(r)), 8'(clip8(g)), 8'(clip8(b))};
  endfunction

  task automatic queueLine(input int len);
    yuvRgbPkg::rgbPair_t e;
    for (int j = 0; j < len; j++) begin
      {e.rEven, e.gEven, e.bEven} = rgbRef(yE[j], uS[j], vS[j]);
      {e.rOdd, e.gOdd, e.bOdd} =
        rgbRef(yO[j], oddChromaRef(1'b0, j, len), oddChromaRef(1'b1, j, len));
      e.lastInLine = (j == len - 1);
      expQ.push_back(e);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // output collector, beats in order

  always @(posedge Clock_50_I) begin
    yuvRgbPkg::rgbPair_t e;
    if (Resetn && rgbValid && rgbReady) begin
      assert (expQ.size() > 0)
        else stopRun("Output beat arrived when no pair was expected");
      e = expQ.pop_front();
      assert (rgbPair == e)
        else stopRun($sformatf("Error at %0d ns: rgbPair expected %h, got %h",
                               $time, e, rgbPair));
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // stimulus helpers

  // optional config write while pair writeAt is on the input
  task automatic sendLine(input int len, input int writeAt, input int writeVal);
    for (int j = 0; j < len; j++) begin
      @(negedge Clock_50_I);
      inPair.yEven = 8'(yE[j]);
      inPair.yOdd  = 8'(yO[j]);
      inPair.u     = 8'(uS[j]);
      inPair.v     = 8'(vS[j]);
      inValid      = 1'b1;
      cfgWrite     = (j == writeAt);
      if (j == writeAt) begin
        cfgData = 9'(writeVal);
      end
      @(posedge Clock_50_I);
      while (!inReady) begin
        @(posedge Clock_50_I);
      end
    end
    @(negedge Clock_50_I);
    inValid  = 1'b0;
    cfgWrite = 1'b0;
  endtask

  task automatic fillRandom(input int len);
    for (int j = 0; j < len; j++) begin
      yE[j] = $urandom_range(0, 255);
      yO[j] = $urandom_range(0, 255);
      uS[j] = $urandom_range(0, 255);
      vS[j] = $urandom_range(0, 255);
    end
  endtask

  task automatic writeLength(input int len);
    @(negedge Clock_50_I);
    cfgWrite = 1'b1;
    cfgData  = 9'(len);
    @(negedge Clock_50_I);
    cfgWrite = 1'b0;
  endtask

  task automatic waitLength(input int len);
    while (lineLength != 9'(len)) begin
      @(negedge Clock_50_I);
    end
  endtask

  task automatic waitDrain;
    while (expQ.size() != 0) begin
      @(posedge Clock_50_I);
    end
    @(negedge Clock_50_I);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // tests

  task automatic checkReset;
    assert (rgbValid == 1'b0)
      else stopRun($sformatf("Error at %0d ns: rgbValid expected 0, got %b", $time, rgbValid));
    assert (cfgError == 1'b0)
      else stopRun($sformatf("Error at %0d ns: cfgError expected 0, got %b", $time, cfgError));
    assert (lineLength == 9'(`LINE_DEFAULT))
      else stopRun($sformatf("Error at %0d ns: lineLength expected %0d, got %0d",
                             $time, `LINE_DEFAULT, lineLength));
    @(negedge Clock_50_I);
    assert (inReady == 1'b1)
      else stopRun($sformatf("Error at %0d ns: inReady expected 1, got %b", $time, inReady));
  endtask

  task automatic greyLine;
    int levels[5];
    int greyOf[5];
    yuvRgbPkg::rgbPair_t e;
    levels = '{0, 16, 128, 235, 255};
    // grey level of each Y above from the clipped luma term alone
    greyOf = '{0, 0, 130, 254, 255};
    for (int j = 0; j < `LINE_DEFAULT; j++) begin
      yE[j] = levels[(2 * j) % 5];
      yO[j] = levels[(2 * j + 1) % 5];
      uS[j] = 128;
      vS[j] = 128;
      e.rEven      = 8'(greyOf[(2 * j) % 5]);
      e.gEven      = e.rEven;
      e.bEven      = e.rEven;
      e.rOdd       = 8'(greyOf[(2 * j + 1) % 5]);
      e.gOdd       = e.rOdd;
      e.bOdd       = e.rOdd;
      e.lastInLine = (j == `LINE_DEFAULT - 1);
      expQ.push_back(e);
    end
    sendLine(`LINE_DEFAULT, -1, 0);
    waitDrain();
  endtask

  // same samples twice, the second time under random back-pressure
  task automatic randomLines;
    fillRandom(`LINE_DEFAULT);
    queueLine(`LINE_DEFAULT);
    sendLine(`LINE_DEFAULT, -1, 0);
    waitDrain();
    randomReady = 1'b1;
    queueLine(`LINE_DEFAULT);
    sendLine(`LINE_DEFAULT, -1, 0);
    waitDrain();
    randomReady = 1'b0;
  endtask

  task automatic lengthChange;
    writeLength(4);
    waitLength(4);
    for (int n = 0; n < 2; n++) begin
      fillRandom(4);
      queueLine(4);
      sendLine(4, -1, 0);
    end
    waitDrain();
    writeLength(300);
    @(negedge Clock_50_I);
    assert (cfgError == 1'b1)
      else stopRun($sformatf("Error at %0d ns: cfgError expected 1, got %b", $time, cfgError));
    assert (lineLength == 9'd4)
      else stopRun($sformatf("Error at %0d ns: lineLength expected 4, got %0d",
                             $time, lineLength));
  endtask

  task automatic deferredWrite;
    fillRandom(4);
    queueLine(4);
    sendLine(4, 2, 8);
    assert (lineLength == 9'd8)
      else stopRun($sformatf("Error at %0d ns: lineLength expected 8, got %0d",
                             $time, lineLength));
    fillRandom(8);
    queueLine(8);
    sendLine(8, -1, 0);
    waitDrain();
  endtask

  initial begin
    Resetn      = 1'b0;
    inPair      = '0;
    inValid     = 1'b0;
    rgbReady    = 1'b1;
    cfgWrite    = 1'b0;
    cfgData     = '0;
    randomReady = 1'b0;
    void'($urandom(32'h2cdb));
    repeat (10) @(negedge Clock_50_I);
    Resetn = 1'b1;

    checkReset();
    greyLine();
    randomLines();
    lengthChange();
    deferredWrite();

    // quiet period so a stray extra beat would still be caught
    repeat (20) @(negedge Clock_50_I);
    $display("Testbench passed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+rtl
rtl/yuvRgbPkg.sv
rtl/lineConfig.sv
rtl/chromaWindow.sv
rtl/chromaInterp.sv
rtl/colorConvert.sv
rtl/yuvToRgbTop.sv
bench/tbYuvToRgb.sv

// ==== rtl/chromaInterp.sv ====
// taps arrive edge-replicated from the window stage; result is one registered beat
`timescale 1ns/1ps
`default_nettype none

`include "yuvRgb_params.svh"

module chromaInterp (
  input  wire                         Clock_50_I,
  input  wire                         Resetn,
  input  wire yuvRgbPkg::chromaWin_t  win,
  input  wire                         winValid,
  input  wire                         yuvReady,
  output logic                        winReady,
  output yuvRgbPkg::yuv444Pair_t      yuv,
  output logic                        yuvValid
);

  // six-tap symmetric filter, rounded then clipped to a sample
  function automatic yuvRgbPkg::sample_t oddChroma(input yuvRgbPkg::sample_t [5:0] t);
    yuvRgbPkg::acc_t outer;
    yuvRgbPkg::acc_t inner;
    yuvRgbPkg::acc_t centre;
    yuvRgbPkg::acc_t sum;
    outer  = t[0] + t[5];
    inner  = t[1] + t[4];
    centre = t[2] + t[3];
    sum = `FIR_C0 * outer - `FIR_C1 * inner + `FIR_C2 * centre + `FIR_ROUND;
    sum = sum >>> `FIR_SHIFT;
    if (sum < 0) begin
      return '0;
    end
    if (sum > 255) begin
      return 8'hff;
    end
    return sum[7:0];
  endfunction

  assign winReady = !yuvValid || yuvReady;

  always_ff @(posedge Clock_50_I or negedge Resetn) begin
    if (!Resetn) begin
      yuvValid <= 1'b0;
    end else if (winReady) begin
      yuvValid <= winValid;
    end
  end

  always_ff @(posedge Clock_50_I) begin
    if (winValid && winReady) begin
      yuv.yEven      <= win.yEven;
      yuv.yOdd       <= win.yOdd;
      yuv.uEven      <= win.uTap[2];
      yuv.vEven      <= win.vTap[2];
      yuv.uOdd       <= oddChroma(win.uTap);
      yuv.vOdd       <= oddChroma(win.vTap);
      yuv.lastInLine <= win.lastInLine;
    end
  end

  // incoming window held until this stage takes it
  assert property (@(posedge Clock_50_I) disable iff (!Resetn)
    winValid && !winReady |=> winValid && $stable(win));

endmodule

`default_nettype wire

// ==== rtl/chromaWindow.sv ====
// line length must be at least 4 pairs; each line ends with a three-window flush
`timescale 1ns/1ps
`default_nettype none

module chromaWindow (
  input  wire                       Clock_50_I,
  input  wire                       Resetn,
  input  wire yuvRgbPkg::yuvPair_t  inPair,
  input  wire                       inValid,
  input  wire yuvRgbPkg::lineLen_t  lineLength,
  input  wire                       winReady,
  output logic                      inReady,
  output yuvRgbPkg::chromaWin_t     win,
  output logic                      winValid,
  output logic                      lineBoundary
);

  // flush states count the windows still to be shifted out
  typedef enum logic [1:0] {
    ST_STREAM,
    ST_FLUSH3,
    ST_FLUSH2,
    ST_FLUSH1
  } winState_e;

  winState_e state;
  yuvRgbPkg::pairIdx_t pairCnt;
  logic readyEn;
  logic inAccept;
  logic winTake;
  logic isLast;
  logic lastWin;
  yuvRgbPkg::sample_t [3:0] yEvenDly;
  yuvRgbPkg::sample_t [3:0] yOddDly;
  yuvRgbPkg::sample_t [5:0] uTap;
  yuvRgbPkg::sample_t [5:0] vTap;

  assign inReady  = readyEn && (state == ST_STREAM) && (!winValid || winReady);
  assign inAccept = inValid && inReady;
  assign winTake  = winValid && winReady;
  assign isLast   = ({1'b0, pairCnt} == lineLength - 9'd1);
  // idle between lines counts as a boundary too
  assign lineBoundary = inAccept ? isLast : (pairCnt == '0);

  ////////////////////////////////////////////////////////////////////////////
  // line position and window valid

  always_ff @(posedge Clock_50_I or negedge Resetn) begin
    if (!Resetn) begin
      readyEn  <= 1'b0;
      state    <= ST_STREAM;
      pairCnt  <= '0;
      winValid <= 1'b0;
    end else begin
      readyEn <= 1'b1;
      if (inAccept) begin
        pairCnt  <= isLast ? '0 : pairCnt + 8'd1;
        winValid <= (pairCnt >= 8'd3);
        if (isLast) begin
          state <= ST_FLUSH3;
        end
      end else if (winTake) begin
        case (state)
          ST_FLUSH3: state <= ST_FLUSH2;
          ST_FLUSH2: state <= ST_FLUSH1;
          ST_FLUSH1: state <= ST_STREAM;
          default:   winValid <= 1'b0;
        endcase
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // sample shift registers

  always_ff @(posedge Clock_50_I) begin
    if (inAccept) begin
      yEvenDly <= {inPair.yEven, yEvenDly[3:1]};
      yOddDly  <= {inPair.yOdd, yOddDly[3:1]};
      lastWin  <= 1'b0;
      // left edge, all older taps copy the first sample
      if (pairCnt == '0) begin
        uTap <= {6{inPair.u}};
        vTap <= {6{inPair.v}};
      end else begin
        uTap <= {inPair.u, uTap[5:1]};
        vTap <= {inPair.v, vTap[5:1]};
      end
    end else if (winTake && (state != ST_STREAM)) begin
      // right edge repeats the newest chroma
      yEvenDly <= {yEvenDly[3], yEvenDly[3:1]};
      yOddDly  <= {yOddDly[3], yOddDly[3:1]};
      uTap     <= {uTap[5], uTap[5:1]};
      vTap     <= {vTap[5], vTap[5:1]};
      lastWin  <= (state == ST_FLUSH1);
    end
  end

  always_comb begin
    win.yEven      = yEvenDly[0];
    win.yOdd       = yOddDly[0];
    win.uTap       = uTap;
    win.vTap       = vTap;
    win.lastInLine = lastWin;
  end

  assert property (@(posedge Clock_50_I) disable iff (!Resetn)
    {1'b0, pairCnt} < lineLength);

  // a flush always has a window on the output and the input closed
  assert property (@(posedge Clock_50_I) disable iff (!Resetn)
    (state != ST_STREAM) |-> winValid && !inReady);

endmodule

`default_nettype wire

// ==== rtl/colorConvert.sv ====
// BT.601 studio-range input assumed; every colour is clipped to 0..255
`timescale 1ns/1ps
`default_nettype none

`include "yuvRgb_params.svh"

module colorConvert (
  input  wire                          Clock_50_I,
  input  wire                          Resetn,
  input  wire yuvRgbPkg::yuv444Pair_t  yuv,
  input  wire                          yuvValid,
  input  wire                          rgbReady,
  output logic                         yuvReady,
  output yuvRgbPkg::rgbPair_t          rgbPair,
  output logic                         rgbValid
);

  logic [23:0] rgbEven;
  logic [23:0] rgbOdd;

  function automatic yuvRgbPkg::sample_t clipShift(input yuvRgbPkg::acc_t x);
    yuvRgbPkg::acc_t s;
    s = x >>> `CSC_SHIFT;
    if (s < 0) begin
      return '0;
    end
    if (s > 255) begin
      return 8'hff;
    end
    return s[7:0];
  endfunction

  // one pixel, packed as {R, G, B}
  function automatic logic [23:0] pixelRgb(input yuvRgbPkg::sample_t y, u, v);
    yuvRgbPkg::acc_t yTerm;
    yuvRgbPkg::acc_t uOff;
    yuvRgbPkg::acc_t vOff;
    yTerm = `COEF_Y * ($signed({1'b0, y}) - `Y_OFFSET);
    uOff  = $signed({1'b0, u}) - `C_OFFSET;
    vOff  = $signed({1'b0, v}) - `C_OFFSET;
    return {clipShift(yTerm + `COEF_RV * vOff),
            clipShift(yTerm - `COEF_GU * uOff - `COEF_GV * vOff),
            clipShift(yTerm + `COEF_BU * uOff)};
  endfunction

  assign rgbEven  = pixelRgb(yuv.yEven, yuv.uEven, yuv.vEven);
  assign rgbOdd   = pixelRgb(yuv.yOdd, yuv.uOdd, yuv.vOdd);
  assign yuvReady = !rgbValid || rgbReady;

  ////////////////////////////////////////////////////////////////////////////
  // output stage

  always_ff @(posedge Clock_50_I or negedge Resetn) begin
    if (!Resetn) begin
      rgbValid <= 1'b0;
    end else if (yuvReady) begin
      rgbValid <= yuvValid;
    end
  end

  always_ff @(posedge Clock_50_I) begin
    if (yuvValid && yuvReady) begin
      rgbPair <= {rgbEven, rgbOdd, yuv.lastInLine};
    end
  end

  assert property (@(posedge Clock_50_I) disable iff (!Resetn)
    rgbValid && !rgbReady |=> rgbValid && $stable(rgbPair));

endmodule

`default_nettype wire

// ==== rtl/lineConfig.sv ====
// a valid write waits for the next line boundary; a bad write is flagged until reset
`timescale 1ns/1ps
`default_nettype none

`include "yuvRgb_params.svh"

module lineConfig (
  input  wire                       Clock_50_I,
  input  wire                       Resetn,
  input  wire                       cfgWrite,
  input  wire yuvRgbPkg::lineLen_t  cfgData,
  input  wire                       lineBoundary,
  output yuvRgbPkg::lineLen_t       lineLength,
  output logic                      cfgError
);

  yuvRgbPkg::lineLen_t pendLen;
  logic pendValid;
  logic inRange;

  assign inRange = (cfgData >= `LINE_MIN) && (cfgData <= `LINE_MAX);

  always_ff @(posedge Clock_50_I or negedge Resetn) begin
    if (!Resetn) begin
      lineLength <= yuvRgbPkg::lineLen_t'(`LINE_DEFAULT);
      pendValid  <= 1'b0;
      cfgError   <= 1'b0;
    end else begin
      if (lineBoundary && pendValid) begin
        lineLength <= pendLen;
        pendValid  <= 1'b0;
      end
      // a write in the boundary cycle waits for the following one
      if (cfgWrite) begin
        if (inRange) begin
          pendValid <= 1'b1;
        end else begin
          cfgError <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge Clock_50_I) begin
    if (cfgWrite && inRange) begin
      pendLen <= cfgData;
    end
  end

  // length only moves on a boundary, and only to a legal value
  assert property (@(posedge Clock_50_I) disable iff (!Resetn)
    !$stable(lineLength) |-> $past(lineBoundary) &&
      (lineLength >= `LINE_MIN) && (lineLength <= `LINE_MAX));

endmodule

`default_nettype wire

// ==== rtl/yuvRgbPkg.sv ====
// types only; every width follows from 8-bit samples and at most 256 pairs per line
`default_nettype none

package yuvRgbPkg;

  typedef logic [7:0] sample_t;
  typedef logic [8:0] lineLen_t;
  typedef logic [7:0] pairIdx_t;
  typedef logic signed [31:0] acc_t;

  // input beat, U and V shared by both pixels
  typedef struct packed {
    sample_t yEven;
    sample_t yOdd;
    sample_t u;
    sample_t v;
  } yuvPair_t;

  // tap 0 is the oldest sample, tap 2 sits on the even pixel
  typedef struct packed {
    sample_t       yEven;
    sample_t       yOdd;
    sample_t [5:0] uTap;
    sample_t [5:0] vTap;
    logic          lastInLine;
  } chromaWin_t;

  typedef struct packed {
    sample_t yEven;
    sample_t yOdd;
    sample_t uEven;
    sample_t vEven;
    sample_t uOdd;
    sample_t vOdd;
    logic    lastInLine;
  } yuv444Pair_t;

  typedef struct packed {
    sample_t rEven;
    sample_t gEven;
    sample_t bEven;
    sample_t rOdd;
    sample_t gOdd;
    sample_t bOdd;
    logic    lastInLine;
  } rgbPair_t;

endpackage

`default_nettype wire

// ==== rtl/yuvRgb_params.svh ====
// fixed-point constants for 8-bit samples only; line lengths count pixel pairs, not pixels
`ifndef YUVRGB_PARAMS_SVH
`define YUVRGB_PARAMS_SVH

////////////////////////////////////////////////////////////////////////////
// colour-space conversion, coefficients scaled by 2^16

`define COEF_Y    76284
`define COEF_RV   104595
`define COEF_GU   25624
`define COEF_GV   53281
`define COEF_BU   132251

`define Y_OFFSET  16
`define C_OFFSET  128
`define CSC_SHIFT 16

////////////////////////////////////////////////////////////////////////////
// chroma upsampler, taps scaled by 2^8

`define FIR_C0    21
`define FIR_C1    52
`define FIR_C2    159
`define FIR_ROUND 128
`define FIR_SHIFT 8

// line length limits, in pairs
`define LINE_MIN     4
`define LINE_MAX     256
`define LINE_DEFAULT 160

`endif

// ==== rtl/yuvToRgbTop.sv ====
// one pixel pair per beat each way; latency varies with the three-pair chroma lookahead
`timescale 1ns/1ps
`default_nettype none

module yuvToRgbTop (
  input  wire                       Clock_50_I,
  input  wire                       Resetn,
  input  wire yuvRgbPkg::yuvPair_t  inPair,
  input  wire                       inValid,
  input  wire                       rgbReady,
  input  wire                       cfgWrite,
  input  wire yuvRgbPkg::lineLen_t  cfgData,
  output logic                      inReady,
  output yuvRgbPkg::rgbPair_t       rgbPair,
  output logic                      rgbValid,
  output yuvRgbPkg::lineLen_t       lineLength,
  output logic                      cfgError
);

  logic lineBoundary;
  yuvRgbPkg::chromaWin_t win;
  logic winValid;
  logic winReady;
  yuvRgbPkg::yuv444Pair_t yuv;
  logic yuvValid;
  logic yuvReady;

  lineConfig u_lineConfig (
    .Clock_50_I   (Clock_50_I),
    .Resetn       (Resetn),
    .cfgWrite     (cfgWrite),
    .cfgData      (cfgData),
    .lineBoundary (lineBoundary),
    .lineLength   (lineLength),
    .cfgError     (cfgError)
  );

  chromaWindow u_chromaWindow (
    .Clock_50_I   (Clock_50_I),
    .Resetn       (Resetn),
    .inPair       (inPair),
    .inValid      (inValid),
    .lineLength   (lineLength),
    .winReady     (winReady),
    .inReady      (inReady),
    .win          (win),
    .winValid     (winValid),
    .lineBoundary (lineBoundary)
  );

  chromaInterp u_chromaInterp (
    .Clock_50_I (Clock_50_I),
    .Resetn     (Resetn),
    .win        (win),
    .winValid   (winValid),
    .yuvReady   (yuvReady),
    .winReady   (winReady),
    .yuv        (yuv),
    .yuvValid   (yuvValid)
  );

  colorConvert u_colorConvert (
    .Clock_50_I (Clock_50_I),
    .Resetn     (Resetn),
    .yuv        (yuv),
    .yuvValid   (yuvValid),
    .rgbReady   (rgbReady),
    .yuvReady   (yuvReady),
    .rgbPair    (rgbPair),
    .rgbValid   (rgbValid)
  );

endmodule

`default_nettype wire

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the YUV to RGB testbench with Verilator from the project root.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tbYuvToRgb -f list.f -o simYuvToRgb > build.log 2>&1
if [ $? -ne 0 ]; then
  cat build.log
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/simYuvToRgb > sim.log 2>&1
simStatus=$?
cat sim.log
if [ $simStatus -ne 0 ]; then
  echo "Simulation exited with status $simStatus"
  exit 1
fi

if grep -q "Testbench failed" sim.log; then
  exit 1
fi
exit 0
